// ==== filelist.f ====
verilog/attn_pkg.sv
verilog/mm_if.sv
verilog/matmul_array.sv
verilog/softmax_row.sv
verilog/attn_ctrl.sv
verilog/attn_top.sv
sim/attn_asserts.sv
sim/attn_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module attn_tb -f filelist.f -Mdir obj_dir -o attn_sim

status=0
./obj_dir/attn_sim +verilator+error+limit+100 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Errors found" sim.log || [ "$status" -ne 0 ]; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

// ==== sim/attn_asserts.sv ====
module attn_ctrl_asserts
    import attn_pkg::*;
(
    input logic        I_CLK,
    input logic        I_ASYN_RSTN,
    input attn_state_t state,
    input logic        clr,
    input logic        start,
    input logic        sm_start,
    input logic        busy,
    input logic        data_vld
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_count;

    initial fail_count = 0;

    //////////////////////////////
    // array handshake
    //////////////////////////////
    a_clr_then_start : assert property (@(posedge I_CLK) disable iff (!I_ASYN_RSTN)
        clr |=> start)
        else begin
            $error("start did not follow clr");
            fail_count++;
        end

    a_start_pulse : assert property (@(posedge I_CLK) disable iff (!I_ASYN_RSTN)
        start |-> $past(clr) && !$past(start))
        else begin
            $error("start not a single pulse after clr");
            fail_count++;
        end

    // output flags
    a_vld_in_done : assert property (@(posedge I_CLK) disable iff (!I_ASYN_RSTN)
        data_vld |-> state == DONE)
        else begin
            $error("data_vld high outside DONE");
            fail_count++;
        end

    a_sm_in_run_sm : assert property (@(posedge I_CLK) disable iff (!I_ASYN_RSTN)
        sm_start |-> state == RUN_SM)
        else begin
            $error("sm_start high outside RUN_SM");
            fail_count++;
        end

    a_busy_vld : assert property (@(posedge I_CLK) disable iff (!I_ASYN_RSTN)
        !(busy && data_vld))
        else begin
            $error("busy and data_vld high together");
            fail_count++;
        end

endmodule

bind attn_ctrl attn_ctrl_asserts u_ctrl_asserts (
    .I_CLK       (I_CLK),
    .I_ASYN_RSTN (I_ASYN_RSTN),
    .state       (state),
    .clr         (mm.clr),
    .start       (mm.start),
    .sm_start    (sm_start),
    .busy        (busy),
    .data_vld    (data_vld)
);

// ==== sim/attn_tb.sv ====
module attn_tb
    import attn_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int    CLK_PERIOD  = 100;
    localparam int    DRIVE_DLY   = 10;                    // after the rising edge
    localparam int    RST_CYCLES  = 5;
    localparam int    TEST_CYCLES = 400;                   // budget for one test
    localparam string TEST_FILE   = "sim/attn_tests.txt";

    logic             I_CLK;
    logic             I_ASYN_RSTN;
    logic             attn_start;
    logic [MAT_W-1:0] q_mat;
    logic [MAT_W-1:0] k_mat;
    logic [MAT_W-1:0] v_mat;
    logic             busy;
    logic             data_vld;
    logic [MAT_W-1:0] o_mat;

    logic [MAT_W-1:0] q_list   [$];
    logic [MAT_W-1:0] k_list   [$];
    logic [MAT_W-1:0] v_list   [$];
    logic [MAT_W-1:0] exp_list [$];
    int               num_tests;
    int               errors;
    int               passed;
    int               failed;
    int               assert_fails;
    logic             load_done;

    attn_top UUT (
        .I_CLK       (I_CLK),
        .I_ASYN_RSTN (I_ASYN_RSTN),
        .attn_start  (attn_start),
        .q_mat       (q_mat),
        .k_mat       (k_mat),
        .v_mat       (v_mat),
        .busy        (busy),
        .data_vld    (data_vld),
        .o_mat       (o_mat)
    );

    initial begin : clock_gen
        I_CLK = 1'b0;
        forever #(CLK_PERIOD / 2) I_CLK = ~I_CLK;
    end

    //////////////////////////////
    // helpers
    //////////////////////////////
    task automatic next_cycle();
        @(posedge I_CLK);
        #DRIVE_DLY;  // outputs settled, inputs may change
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        assert (actual === expected) else begin
            $display("FAILED at %0t ns: %s expected %b, actual %b",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_mat(input logic [MAT_W-1:0] expected);
        assert (o_mat === expected) else begin
            $display("FAILED at %0t ns: o_mat expected %h, actual %h",
                     $time, expected, o_mat);
            errors++;
        end
    endtask

    task automatic read_tests();
        int               fd;
        int               n;
        logic [MAT_W-1:0] q;
        logic [MAT_W-1:0] k;
        logic [MAT_W-1:0] v;
        logic [MAT_W-1:0] e;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            $display("cannot open the test file %s", TEST_FILE);
        end else begin
            n = $fscanf(fd, "%h %h %h %h\n", q, k, v, e);
            while (n == 4) begin
                q_list.push_back(q);
                k_list.push_back(k);
                v_list.push_back(v);
                exp_list.push_back(e);
                n = $fscanf(fd, "%h %h %h %h\n", q, k, v, e);
            end
            $fclose(fd);
        end
        num_tests = q_list.size();
    endtask

    // one attention pass, optionally with an extra start while busy
    task automatic run_test(input int idx, input bit pulse_while_busy);
        int   cycles;
        int   err_start;
        int   alt;    // operands a wrong restart would pick up
        logic seen;
        err_start  = errors;
        alt        = (idx + 1) % num_tests;
        q_mat      = q_list[idx];
        k_mat      = k_list[idx];
        v_mat      = v_list[idx];
        attn_start = 1'b1;
        next_cycle();
        attn_start = 1'b0;
        check_bit("busy", busy, 1'b1);          // start accepted
        check_bit("data_vld", data_vld, 1'b0);  // old result dropped
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < TEST_CYCLES) begin
            next_cycle();
            cycles++;
            if (data_vld) begin
                seen = 1'b1;
            end else begin
                check_bit("busy", busy, 1'b1);
                if (pulse_while_busy && cycles == 3) begin
                    attn_start = 1'b1;  // must be ignored
                    q_mat      = q_list[alt];
                    k_mat      = k_list[alt];
                end else begin
                    attn_start = 1'b0;
                    q_mat      = q_list[idx];
                    k_mat      = k_list[idx];
                end
            end
        end
        assert (seen) else begin
            $display("test %0d: data_vld did not rise within %0d cycles", idx, TEST_CYCLES);
            errors++;
        end
        if (seen) begin
            check_bit("busy", busy, 1'b0);
            check_mat(exp_list[idx]);
        end
        if (errors == err_start) begin
            passed++;
            $display("PASSED test %0d after %0d cycles", idx, cycles);
        end else begin
            failed++;
            $display("FAILED test %0d", idx);
        end
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////
    initial begin : main
        I_ASYN_RSTN = 1'b0;
        attn_start  = 1'b0;
        q_mat       = '0;
        k_mat       = '0;
        v_mat       = '0;
        errors      = 0;
        passed      = 0;
        failed      = 0;
        load_done   = 1'b0;
        read_tests();
        load_done = 1'b1;
        assert (num_tests > 0) else begin
            $display("no tests could be read from %s", TEST_FILE);
            errors++;
        end
        repeat (RST_CYCLES) @(posedge I_CLK);
        #DRIVE_DLY;
        I_ASYN_RSTN = 1'b1;
        next_cycle();
        check_bit("busy", busy, 1'b0);  // idle after reset
        check_bit("data_vld", data_vld, 1'b0);
        check_mat('0);
        for (int t = 0; t < num_tests; t++) begin
            run_test(t, t == 0);  // back to back from DONE
        end
        if (num_tests > 0) begin
            next_cycle();
            next_cycle();
            check_bit("data_vld", data_vld, 1'b1);  // result holds
            check_bit("busy", busy, 1'b0);
            check_mat(exp_list[num_tests-1]);
        end
        assert_fails = UUT.u_ctrl.u_ctrl_asserts.fail_count;
        $display("%0d tests: %0d passed, %0d failed, %0d check errors, %0d assertion failures",
                 num_tests, passed, failed, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin : watchdog
        int limit;
        wait (load_done);
        limit = num_tests * TEST_CYCLES + RST_CYCLES + 10;
        repeat (limit) @(posedge I_CLK);
        $display("timeout: the run went past %0d clock cycles", limit);
        $display("Errors found");
        $finish;
    end

endmodule

// ==== sim/attn_tests.txt ====
00000000000000000000000000000000 00000000000000000000000000000000 7FC450287FCE3C1E7FD828147FE2140A 7FD332197FD332197FD332197FD33219
40000000004000000000400000000040 40000000004000000000400000000040 7FC450287FCE3C1E7FD828147FE2140A 6FCF3E1F6FD532196FDB25126FE2190C
40000000004000000000400000000040 C000000000C000000000C000000000C0 7FC450287FCE3C1E7FD828147FE2140A 77DA251277D72B1577D4321977D1381C
000000E0000000300000002000000010 000000F0000000400000002000000010 003020C04010F030E000102020F00010 021F17D8100600241C06FC221C07FE1A
00000000000000000000000000000000 00000000000000000000000000000000 80808080808080808080808080808080 80808080808080808080808080808080
10000000001000000000100000000010 10000000001000000000100000000010 003020C04010F030E000102020F00010 100C0808100C0808100C0808100C0808
00000000000000000000000000000000 00000000000000000000000000000000 10000000001000000000100000000010 04040404040404040404040404040404
40000000004000000000400000000040 40000000004000000000400000000040 10000000001000000000100000000010 0B010101010B010101010B010101010B
40000000004000000000400000000040 C000000000C000000000C000000000C0 10000000001000000000100000000010 00050505050005050505000505050500
000000E0000000300000002000000010 000000F0000000400000002000000010 10000000001000000000100000000010 0B000102000707010008040201070303

// ==== verilog/attn_ctrl.sv ====
module attn_ctrl
    import attn_pkg::*;
(
    input  logic  I_CLK,
    input  logic  I_ASYN_RSTN,
    input  logic  attn_start,
    input  mat_t  q,
    input  mat_t  k,
    input  mat_t  v,
    mm_if.ctrl    mm,
    output logic  sm_start,
    output elem_t sm_row_in  [D_K],
    input  logic  sm_vld,
    input  elem_t sm_row_out [D_K],
    output logic  busy,
    output logic  data_vld,
    output mat_t  o
);

    attn_state_t      state;
    logic [ROW_W-1:0] row;     // softmax row counter
    logic             accept;
    logic             last_row;
    mat_t             k_t;
    mat_t             scale;   // diagonal d

    assign accept   = attn_start && (state == IDLE || state == DONE);
    assign last_row = sm_vld && (row == ROW_W'(SEQ_LEN - 1));

    always_comb begin
        for (int i = 0; i < SEQ_LEN; i++) begin
            for (int j = 0; j < D_K; j++) begin
                k_t[j][i]   = k[i][j];
                scale[i][j] = (i == j) ? elem_t'(SCALE_VAL) : '0;
            end
        end
    end

    assign sm_row_in = mm.mat_a[row];

    //////////////////////////////
    // sequencing
    //////////////////////////////
    always_ff @(posedge I_CLK or negedge I_ASYN_RSTN) begin
        if (!I_ASYN_RSTN) begin
            state    <= IDLE;
            row      <= '0;
            mm.clr   <= 1'b0;
            mm.start <= 1'b0;
            sm_start <= 1'b0;
            busy     <= 1'b0;
            data_vld <= 1'b0;
            o        <= '{default: '0};
        end else begin
            mm.clr   <= 1'b0;
            mm.start <= 1'b0;
            unique case (state)
                IDLE, DONE: begin
                    if (accept) begin
                        state    <= LOAD_QK;
                        mm.clr   <= 1'b1;
                        busy     <= 1'b1;
                        data_vld <= 1'b0;
                    end
                end
                LOAD_QK: begin
                    mm.start <= 1'b1;
                    state    <= RUN_QK;
                end
                RUN_QK: begin
                    if (mm.vld) begin
                        mm.clr <= 1'b1;
                        state  <= LOAD_SC;
                    end
                end
                LOAD_SC: begin
                    mm.start <= 1'b1;
                    state    <= RUN_SC;
                end
                RUN_SC: begin
                    if (mm.vld) begin
                        sm_start <= 1'b1;  // level for the whole phase
                        row      <= '0;
                        state    <= RUN_SM;
                    end
                end
                RUN_SM: begin
                    if (sm_vld) begin
                        row <= row + 1'b1;
                    end
                    if (last_row) begin
                        sm_start <= 1'b0;
                        mm.clr   <= 1'b1;
                        state    <= LOAD_PV;
                    end
                end
                LOAD_PV: begin
                    mm.start <= 1'b1;
                    state    <= RUN_PV;
                end
                RUN_PV: begin
                    if (mm.vld) begin
                        o        <= mm.res;  // held until next start
                        data_vld <= 1'b1;
                        busy     <= 1'b0;
                        state    <= DONE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // operands stay put from clr until vld
    always_ff @(posedge I_CLK) begin
        unique case (state)
            IDLE, DONE: begin
                if (accept) begin
                    mm.mat_a <= q;
                    mm.mat_b <= k_t;
                end
            end
            RUN_QK: begin
                if (mm.vld) begin
                    mm.mat_a <= mm.res;  // s
                    mm.mat_b <= scale;
                end
            end
            RUN_SC: begin
                if (mm.vld) begin
                    mm.mat_a <= mm.res;  // s', rows go to softmax
                end
            end
            RUN_SM: begin
                if (sm_vld) begin
                    mm.mat_a[row] <= sm_row_out;
                end
                if (last_row) begin
                    mm.mat_b <= v;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== verilog/attn_pkg.sv ====
package attn_pkg;

    //////////////////////////////
    // sizes
    //////////////////////////////
    localparam int DATA_W  = 8;                       // Q4.4 element
    localparam int SEQ_LEN = 4;                       // rows of q, k, v
    localparam int D_K     = 4;                       // head dimension
    localparam int ACC_W   = 20;                      // mac accumulator
    localparam int MAT_W   = SEQ_LEN * D_K * DATA_W;  // flat matrix bus
    localparam int ROW_W   = $clog2(SEQ_LEN);
    localparam int COL_W   = $clog2(D_K);

    // fixed point
    localparam int FRAC_W    = 4;
    localparam int SCALE_VAL = 8;                     // 0.5 = 1/sqrt(4)
    localparam int ONE_VAL   = 16;                    // 1.0
    localparam int ELEM_MAX  = 127;
    localparam int ELEM_MIN  = -128;

    //////////////////////////////
    // softmax
    //////////////////////////////
    localparam int W_MAX       = 64;                  // weight at the row max
    localparam int W_SHIFT_MAX = 6;
    localparam int WGT_W  = $clog2(W_MAX) + 1;
    localparam int SH_W   = $clog2(W_SHIFT_MAX + 1);
    localparam int SUM_W  = WGT_W + $clog2(D_K);      // sum of one row of weights
    localparam int NUM_W  = WGT_W + $clog2(ONE_VAL);  // w * 1.0
    localparam int REM_W  = SUM_W + 1;                // partial remainder
    localparam int STEP_W = $clog2(DATA_W);           // one quotient bit per step

    // array pass ends one cycle after the last MAC lands in cell (3,3)
    localparam int MM_CNT_END = SEQ_LEN + 2 * D_K - 2;
    localparam int MM_CNT_W   = $clog2(MM_CNT_END + 1);

    typedef logic signed [DATA_W-1:0] elem_t;
    typedef elem_t mat_t [SEQ_LEN][D_K];

    typedef enum logic [8:0] {
        IDLE    = 9'b0_0000_0001,
        LOAD_QK = 9'b0_0000_0010,
        RUN_QK  = 9'b0_0000_0100,  // s = q * k^T
        LOAD_SC = 9'b0_0000_1000,
        RUN_SC  = 9'b0_0001_0000,  // s' = s * d
        RUN_SM  = 9'b0_0010_0000,  // p = softmax(s')
        LOAD_PV = 9'b0_0100_0000,
        RUN_PV  = 9'b0_1000_0000,  // o = p * v
        DONE    = 9'b1_0000_0000
    } attn_state_t;

endpackage

// ==== verilog/attn_top.sv ====
module attn_top
    import attn_pkg::*;
(
    input  logic             I_CLK,
    input  logic             I_ASYN_RSTN,
    input  logic             attn_start,
    input  logic [MAT_W-1:0] q_mat,
    input  logic [MAT_W-1:0] k_mat,
    input  logic [MAT_W-1:0] v_mat,
    output logic             busy,
    output logic             data_vld,
    output logic [MAT_W-1:0] o_mat
);

    mat_t  q_u;
    mat_t  k_u;
    mat_t  v_u;
    mat_t  o_u;
    logic  sm_start;
    logic  sm_vld;
    elem_t sm_row_in  [D_K];
    elem_t sm_row_out [D_K];

    // row 0 col 0 sits in the low byte
    always_comb begin
        for (int i = 0; i < SEQ_LEN; i++) begin
            for (int j = 0; j < D_K; j++) begin
                q_u[i][j] = q_mat[(i * D_K + j) * DATA_W +: DATA_W];
                k_u[i][j] = k_mat[(i * D_K + j) * DATA_W +: DATA_W];
                v_u[i][j] = v_mat[(i * D_K + j) * DATA_W +: DATA_W];
                o_mat[(i * D_K + j) * DATA_W +: DATA_W] = o_u[i][j];
            end
        end
    end

    mm_if u_mm ();

    attn_ctrl u_ctrl (
        .I_CLK       (I_CLK),
        .I_ASYN_RSTN (I_ASYN_RSTN),
        .attn_start  (attn_start),
        .q           (q_u),
        .k           (k_u),
        .v           (v_u),
        .mm          (u_mm),
        .sm_start    (sm_start),
        .sm_row_in   (sm_row_in),
        .sm_vld      (sm_vld),
        .sm_row_out  (sm_row_out),
        .busy        (busy),
        .data_vld    (data_vld),
        .o           (o_u)
    );

    matmul_array u_array (
        .I_CLK       (I_CLK),
        .I_ASYN_RSTN (I_ASYN_RSTN),
        .mm          (u_mm)
    );

    softmax_row u_softmax (
        .I_CLK       (I_CLK),
        .I_ASYN_RSTN (I_ASYN_RSTN),
        .start       (sm_start),
        .row_in      (sm_row_in),
        .vld         (sm_vld),
        .row_out     (sm_row_out)
    );

endmodule

// ==== verilog/matmul_array.sv ====
module matmul_array
    import attn_pkg::*;
(
    input  logic I_CLK,
    input  logic I_ASYN_RSTN,
    mm_if.array  mm
);

    logic                run;
    logic [MM_CNT_W-1:0] cnt;
    logic                feed;  // edge operands still coming in

    elem_t a_edge [SEQ_LEN];
    elem_t b_edge [D_K];
    elem_t a_sk   [SEQ_LEN][SEQ_LEN-1];  // row i delayed by i
    elem_t b_sk   [D_K][D_K-1];          // column j delayed by j
    elem_t a_left [SEQ_LEN];
    elem_t b_top  [D_K];
    elem_t a_in   [SEQ_LEN][D_K];
    elem_t b_in   [SEQ_LEN][D_K];
    elem_t a_pipe [SEQ_LEN][D_K];
    elem_t b_pipe [SEQ_LEN][D_K];
    logic signed [ACC_W-1:0] acc [SEQ_LEN][D_K];

    function automatic elem_t rescale_sat(input logic signed [ACC_W-1:0] v);
        logic signed [ACC_W-1:0] t;
        t = v >>> FRAC_W;
        if (t > ELEM_MAX) begin
            return elem_t'(ELEM_MAX);
        end else if (t < ELEM_MIN) begin
            return elem_t'(ELEM_MIN);
        end
        return elem_t'(t);
    endfunction

    //////////////////////////////
    // pass counter
    //////////////////////////////
    always_ff @(posedge I_CLK or negedge I_ASYN_RSTN) begin
        if (!I_ASYN_RSTN) begin
            run    <= 1'b0;
            cnt    <= '0;
            mm.vld <= 1'b0;
        end else begin
            mm.vld <= 1'b0;
            if (mm.start) begin
                run <= 1'b1;
                cnt <= '0;
            end else if (run) begin
                cnt <= cnt + 1'b1;
                if (cnt == MM_CNT_W'(MM_CNT_END)) begin
                    run    <= 1'b0;
                    mm.vld <= 1'b1;  // 12 cycles after start
                end
            end
        end
    end

    assign feed = run && (int'(cnt) < D_K);

    always_comb begin
        for (int i = 0; i < SEQ_LEN; i++) begin
            a_edge[i] = feed ? mm.mat_a[i][cnt[COL_W-1:0]] : '0;
        end
        for (int j = 0; j < D_K; j++) begin
            b_edge[j] = feed ? mm.mat_b[cnt[COL_W-1:0]][j] : '0;
        end
    end

    // skew registers
    always_ff @(posedge I_CLK) begin
        if (mm.clr) begin
            a_sk <= '{default: '0};
            b_sk <= '{default: '0};
        end else begin
            for (int i = 1; i < SEQ_LEN; i++) begin
                a_sk[i][0] <= a_edge[i];
                for (int s = 1; s < i; s++) begin
                    a_sk[i][s] <= a_sk[i][s-1];
                end
            end
            for (int j = 1; j < D_K; j++) begin
                b_sk[j][0] <= b_edge[j];
                for (int s = 1; s < j; s++) begin
                    b_sk[j][s] <= b_sk[j][s-1];
                end
            end
        end
    end

    always_comb begin
        a_left[0] = a_edge[0];
        b_top[0]  = b_edge[0];
        for (int i = 1; i < SEQ_LEN; i++) begin
            a_left[i] = a_sk[i][i-1];
        end
        for (int j = 1; j < D_K; j++) begin
            b_top[j] = b_sk[j][j-1];
        end
        for (int i = 0; i < SEQ_LEN; i++) begin
            for (int j = 0; j < D_K; j++) begin
                a_in[i][j] = (j == 0) ? a_left[i] : a_pipe[i][(j > 0) ? j - 1 : 0];
                b_in[i][j] = (i == 0) ? b_top[j] : b_pipe[(i > 0) ? i - 1 : 0][j];
            end
        end
    end

    //////////////////////////////
    // mac cells, output stationary
    //////////////////////////////
    always_ff @(posedge I_CLK) begin
        if (mm.clr) begin
            acc    <= '{default: '0};
            a_pipe <= '{default: '0};
            b_pipe <= '{default: '0};
        end else begin
            for (int i = 0; i < SEQ_LEN; i++) begin
                for (int j = 0; j < D_K; j++) begin
                    acc[i][j]    <= acc[i][j] + a_in[i][j] * b_in[i][j];
                    a_pipe[i][j] <= a_in[i][j];  // pass right
                    b_pipe[i][j] <= b_in[i][j];  // pass down
                end
            end
        end
    end

    always_ff @(posedge I_CLK) begin
        if (run && cnt == MM_CNT_W'(MM_CNT_END)) begin
            for (int i = 0; i < SEQ_LEN; i++) begin
                for (int j = 0; j < D_K; j++) begin
                    mm.res[i][j] <= rescale_sat(acc[i][j]);
                end
            end
        end
    end

endmodule

// ==== verilog/mm_if.sv ====
interface mm_if
    import attn_pkg::*;
();

    logic clr;    // clear accumulators
    logic start;  // one cycle after clr
    mat_t mat_a;  // left operand
    mat_t mat_b;  // right operand
    mat_t res;    // rescaled, saturated product
    logic vld;    // single pulse, res ready

    modport ctrl (
        output clr,
        output start,
        output mat_a,
        output mat_b,
        input  res,
        input  vld
    );

    modport array (
        input  clr,
        input  start,
        input  mat_a,
        input  mat_b,
        output res,
        output vld
    );

endinterface

// ==== verilog/softmax_row.sv ====
module softmax_row
    import attn_pkg::*;
(
    input  logic  I_CLK,
    input  logic  I_ASYN_RSTN,
    input  logic  start,
    input  elem_t row_in  [D_K],
    output logic  vld,
    output elem_t row_out [D_K]
);

    typedef enum logic [1:0] {
        SM_IDLE,  // capture row and max
        SM_WGT,
        SM_DIV,
        SM_DONE
    } sm_state_t;

    sm_state_t          state;
    logic [COL_W-1:0]   idx;    // entry being divided
    logic [STEP_W-1:0]  step;
    elem_t              x_r [D_K];
    elem_t              m_r;
    logic [WGT_W-1:0]   w_r [D_K];
    logic [SUM_W-1:0]   sum_r;
    logic [REM_W-1:0]   rem;
    logic [DATA_W-1:0]  num;    // numerator bits not yet shifted in
    logic [DATA_W-1:0]  quo;

    elem_t              row_max;
    logic [WGT_W-1:0]   w_nxt [D_K];
    logic [SUM_W-1:0]   sum_nxt;
    logic [NUM_W-1:0]   numer;
    logic [REM_W-1:0]   rem_cur;
    logic [DATA_W-1:0]  num_cur;
    logic [REM_W-1:0]   trial;
    logic               q_bit;

    always_comb begin
        row_max = row_in[0];
        for (int i = 1; i < D_K; i++) begin
            if (row_in[i] > row_max) begin
                row_max = row_in[i];
            end
        end
    end

    // w = 64 >> min((m - x) >> 4, 6)
    always_comb begin : weights
        logic [DATA_W:0] diff;
        logic [SH_W-1:0] sh;
        sum_nxt = '0;
        for (int i = 0; i < D_K; i++) begin
            diff = {m_r[DATA_W-1], m_r} - {x_r[i][DATA_W-1], x_r[i]};
            diff = diff >> FRAC_W;
            if (int'(diff) > W_SHIFT_MAX) begin
                sh = SH_W'(W_SHIFT_MAX);
            end else begin
                sh = diff[SH_W-1:0];
            end
            w_nxt[i] = WGT_W'(W_MAX) >> sh;
            sum_nxt  = sum_nxt + SUM_W'(w_nxt[i]);
        end
    end

    //////////////////////////////
    // restoring divider
    //////////////////////////////
    assign numer   = NUM_W'(w_r[idx]) * NUM_W'(ONE_VAL);
    assign rem_cur = (step == '0) ? REM_W'(numer >> DATA_W) : rem;  // preload high bits
    assign num_cur = (step == '0) ? numer[DATA_W-1:0] : num;
    assign trial   = {rem_cur[REM_W-2:0], num_cur[DATA_W-1]};
    assign q_bit   = (trial >= REM_W'(sum_r));

    always_ff @(posedge I_CLK or negedge I_ASYN_RSTN) begin
        if (!I_ASYN_RSTN) begin
            state <= SM_IDLE;
            idx   <= '0;
            step  <= '0;
        end else if (!start) begin
            state <= SM_IDLE;
            idx   <= '0;
            step  <= '0;
        end else begin
            unique case (state)
                SM_IDLE: state <= SM_WGT;
                SM_WGT: begin
                    state <= SM_DIV;
                    idx   <= '0;
                    step  <= '0;
                end
                SM_DIV: begin
                    step <= step + 1'b1;  // wraps per entry
                    if (step == STEP_W'(DATA_W - 1)) begin
                        idx <= idx + 1'b1;
                        if (idx == COL_W'(D_K - 1)) begin
                            state <= SM_DONE;
                        end
                    end
                end
                SM_DONE: state <= SM_IDLE;  // next row on the following cycle
            endcase
        end
    end

    always_ff @(posedge I_CLK) begin
        unique case (state)
            SM_IDLE: begin
                x_r <= row_in;
                m_r <= row_max;
            end
            SM_WGT: begin
                w_r   <= w_nxt;
                sum_r <= sum_nxt;
            end
            SM_DIV: begin
                rem <= q_bit ? trial - REM_W'(sum_r) : trial;
                num <= num_cur << 1;
                quo <= {quo[DATA_W-2:0], q_bit};
                if (step == STEP_W'(DATA_W - 1)) begin
                    row_out[idx] <= elem_t'({quo[DATA_W-2:0], q_bit});
                end
            end
            default: begin
            end
        endcase
    end

    assign vld = (state == SM_DONE);

endmodule
